//--- source/exec_pkg.sv
// Shared widths, address map and opcode encodings for the execution subsystem
// All modules refer to these by scoped name

`default_nettype none

package exec_pkg;

  // Register file geometry
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 32;

  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // Host bus address map
  localparam int unsigned WB_ADDR_W = 8;

  typedef logic [WB_ADDR_W-1:0] wb_addr_t;

  // Write here to issue one instruction
  localparam wb_addr_t INSTR_ADDR = 8'h80;
  // Register window 0x00..0x7C, index taken from bits 6:2
  localparam int unsigned REG_IDX_LSB = 2;

  // Opcodes, 3 bits wide
  localparam int unsigned OP_W = 3;

  typedef enum logic [OP_W-1:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6,
    ALU_SLT = 3'd7
  } alu_op_e;

  // Instruction word layout
  localparam int unsigned OP_LSB  = 16;
  localparam int unsigned RD_LSB  = 10;
  localparam int unsigned RS1_LSB = 5;
  localparam int unsigned RS2_LSB = 0;

endpackage

`default_nettype wire

//--- source/rf_req_if.sv
// One register-file access between a requester and the arbiter
// Two reads and an optional write per granted cycle

`default_nettype none

interface rf_req_if;

  logic              req;
  logic              we;
  exec_pkg::reg_addr_t waddr;
  exec_pkg::reg_addr_t raddr_a;
  exec_pkg::reg_addr_t raddr_b;
  exec_pkg::data_t   wdata;
  // Returned by the arbiter
  logic              gnt;
  exec_pkg::data_t   rdata_a;
  exec_pkg::data_t   rdata_b;

  modport requester (output req, we, waddr, raddr_a, raddr_b, wdata,
                     input  gnt, rdata_a, rdata_b);

  modport arbiter   (input  req, we, waddr, raddr_a, raddr_b, wdata,
                     output gnt, rdata_a, rdata_b);

endinterface

`default_nettype wire

//--- source/register_file.sv
// Flip-flop register file, two combinational read ports and one write port
// Register 0 has no storage and always reads as zero

`default_nettype none

module register_file (
  input  logic                clk_i,
  input  logic                rst_ni,

  // Read ports
  input  exec_pkg::reg_addr_t raddr_a_i,
  input  exec_pkg::reg_addr_t raddr_b_i,
  output exec_pkg::data_t     rdata_a_o,
  output exec_pkg::data_t     rdata_b_o,

  // Write port
  input  exec_pkg::reg_addr_t waddr_i,
  input  exec_pkg::data_t     wdata_i,
  input  logic                we_i
);

  // Storage for registers 1..31 only
  exec_pkg::data_t                       regs_q [exec_pkg::NUM_REGS-1:1];
  logic            [exec_pkg::NUM_REGS-1:1] we_dec;

  // One-hot write enable per register
  always_comb begin
    for (int unsigned r = 1; r < exec_pkg::NUM_REGS; r++) begin
      we_dec[r] = we_i && (waddr_i == exec_pkg::reg_addr_t'(r));
    end
  end

  for (genvar g = 1; g < exec_pkg::NUM_REGS; g++) begin : g_regs
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        regs_q[g] <= '0;
      end else if (we_dec[g]) begin
        regs_q[g] <= wdata_i;
      end
    end
  end

  // Index 0 bypasses the array
  always_comb begin
    if (raddr_a_i == '0) begin
      rdata_a_o = '0;
    end else begin
      rdata_a_o = regs_q[raddr_a_i];
    end
  end

  always_comb begin
    if (raddr_b_i == '0) begin
      rdata_b_o = '0;
    end else begin
      rdata_b_o = regs_q[raddr_b_i];
    end
  end

  // An X address would corrupt several registers at once
  a_waddr_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    we_i |-> !$isunknown(waddr_i)
  );

endmodule

`default_nettype wire

//--- source/rf_arbiter.sv
// Fixed-priority arbiter in front of the register file
// Execution unit wins over the host port with one grant per cycle

`default_nettype none

module rf_arbiter (
  input  logic       clk_i,
  input  logic       rst_ni,

  rf_req_if.arbiter  exec_req,
  rf_req_if.arbiter  host_req
);

  logic                sel_exec;
  exec_pkg::reg_addr_t raddr_a;
  exec_pkg::reg_addr_t raddr_b;
  exec_pkg::reg_addr_t waddr;
  exec_pkg::data_t     wdata;
  logic                we;
  exec_pkg::data_t     rdata_a;
  exec_pkg::data_t     rdata_b;

  // Execution unit has priority
  assign sel_exec     = exec_req.req;
  assign exec_req.gnt = exec_req.req;
  assign host_req.gnt = host_req.req && !exec_req.req;

  // Steer the granted side into the array
  assign raddr_a = sel_exec ? exec_req.raddr_a : host_req.raddr_a;
  assign raddr_b = sel_exec ? exec_req.raddr_b : host_req.raddr_b;
  assign waddr   = sel_exec ? exec_req.waddr   : host_req.waddr;
  assign wdata   = sel_exec ? exec_req.wdata   : host_req.wdata;
  // Write only on a granted cycle
  assign we      = (exec_req.gnt && exec_req.we) || (host_req.gnt && host_req.we);

  register_file i_register_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .waddr_i   (waddr),
    .wdata_i   (wdata),
    .we_i      (we)
  );

  // Read data goes to both sides and only the granted one uses it
  assign exec_req.rdata_a = rdata_a;
  assign exec_req.rdata_b = rdata_b;
  assign host_req.rdata_a = rdata_a;
  assign host_req.rdata_b = rdata_b;

  // A waiting host access keeps its request and fields until granted
  a_host_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    host_req.req && !host_req.gnt |=>
      host_req.req && $stable(host_req.we) && $stable(host_req.waddr) &&
      $stable(host_req.raddr_a) && $stable(host_req.wdata)
  );

endmodule

`default_nettype wire

//--- source/alu_exec.sv
// Execution unit for one three-register ALU instruction at a time
// Latches the instruction, reads rs1/rs2 and writes rd in the same granted cycle

`default_nettype none

module alu_exec (
  input  logic            clk_i,
  input  logic            rst_ni,

  // Issue handshake from the host port
  input  logic            instr_valid_i,
  input  exec_pkg::data_t instr_i,
  output logic            instr_ready_o,

  rf_req_if.requester     rf
);

  typedef enum logic {
    IDLE,
    REQ
  } state_e;

  state_e state_q, state_d;

  // Decoded instruction fields
  exec_pkg::alu_op_e   op_q;
  exec_pkg::reg_addr_t rd_q;
  exec_pkg::reg_addr_t rs1_q;
  exec_pkg::reg_addr_t rs2_q;

  exec_pkg::data_t     result;
  logic                accept;

  // Only one instruction in flight
  assign instr_ready_o = (state_q == IDLE);
  assign accept        = instr_valid_i && instr_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (accept) state_d = REQ;
      REQ:  if (rf.gnt) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Fields captured on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q  <= exec_pkg::alu_op_e'(instr_i[exec_pkg::OP_LSB +: exec_pkg::OP_W]);
      rd_q  <= instr_i[exec_pkg::RD_LSB +: exec_pkg::REG_ADDR_W];
      rs1_q <= instr_i[exec_pkg::RS1_LSB +: exec_pkg::REG_ADDR_W];
      rs2_q <= instr_i[exec_pkg::RS2_LSB +: exec_pkg::REG_ADDR_W];
    end
  end

  // Operands arrive combinationally in the grant cycle
  always_comb begin
    case (op_q)
      exec_pkg::ALU_ADD: result = rf.rdata_a + rf.rdata_b;
      exec_pkg::ALU_SUB: result = rf.rdata_a - rf.rdata_b;
      exec_pkg::ALU_AND: result = rf.rdata_a & rf.rdata_b;
      exec_pkg::ALU_OR:  result = rf.rdata_a | rf.rdata_b;
      exec_pkg::ALU_XOR: result = rf.rdata_a ^ rf.rdata_b;
      // Shift amount from low 5 bits of rs2
      exec_pkg::ALU_SLL: result = rf.rdata_a << rf.rdata_b[4:0];
      exec_pkg::ALU_SRL: result = rf.rdata_a >> rf.rdata_b[4:0];
      // Signed compare giving 1 or 0
      exec_pkg::ALU_SLT: begin
        result = {{(exec_pkg::DATA_W-1){1'b0}},
                  ($signed(rf.rdata_a) < $signed(rf.rdata_b))};
      end
      default: result = '0;
    endcase
  end

  // Read rs1/rs2 and write rd in one access
  assign rf.req     = (state_q == REQ);
  assign rf.we      = 1'b1;
  assign rf.waddr   = rd_q;
  assign rf.raddr_a = rs1_q;
  assign rf.raddr_b = rs2_q;
  assign rf.wdata   = result;

  // Highest priority, so a request never has to wait
  a_req_granted: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rf.req |-> rf.gnt
  );

endmodule

`default_nettype wire

//--- source/wb_host_port.sv
// Wishbone classic slave for the host side
// Maps cycles to register reads/writes, instruction issue or unmapped accesses

`default_nettype none

module wb_host_port (
  input  logic                clk_i,
  input  logic                rst_ni,

  // Wishbone slave
  input  logic                cyc_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  exec_pkg::wb_addr_t  adr_i,
  input  exec_pkg::data_t     dat_i,
  output exec_pkg::data_t     dat_o,
  output logic                ack_o,

  // Instruction issue to the execution unit
  output logic                instr_valid_o,
  output exec_pkg::data_t     instr_o,
  input  logic                instr_ready_i,

  rf_req_if.requester         rf
);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    ACK
  } state_e;

  state_e          state_q, state_d;
  exec_pkg::data_t dat_q;

  logic            active;
  logic            is_reg;
  logic            is_issue;
  logic            rf_done;
  logic            issue_done;

  // Address decode, master holds adr/we stable for the whole cycle
  assign active   = cyc_i && stb_i;
  assign is_reg   = !adr_i[exec_pkg::WB_ADDR_W-1];
  assign is_issue = we_i && (adr_i == exec_pkg::INSTR_ADDR);

  assign rf_done    = (state_q == BUSY) && is_reg && rf.gnt;
  assign issue_done = (state_q == BUSY) && is_issue && instr_ready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // Unmapped goes straight to ack
        if (active) state_d = (is_reg || is_issue) ? BUSY : ACK;
      end
      BUSY: begin
        if (!active) begin
          state_d = IDLE;
        end else if (rf_done || issue_done) begin
          state_d = ACK;
        end
      end
      ACK: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Port A data from the grant cycle, zero otherwise
  always_ff @(posedge clk_i) begin
    if (rf_done) begin
      dat_q <= rf.rdata_a;
    end else if (state_q == IDLE) begin
      dat_q <= '0;
    end
  end

  assign ack_o = (state_q == ACK);
  assign dat_o = dat_q;

  // Register access request
  assign rf.req     = (state_q == BUSY) && is_reg;
  assign rf.we      = we_i;
  assign rf.waddr   = adr_i[exec_pkg::REG_IDX_LSB +: exec_pkg::REG_ADDR_W];
  assign rf.raddr_a = adr_i[exec_pkg::REG_IDX_LSB +: exec_pkg::REG_ADDR_W];
  assign rf.raddr_b = '0;
  assign rf.wdata   = dat_i;

  // Instruction word is the write data
  assign instr_valid_o = (state_q == BUSY) && is_issue;
  assign instr_o       = dat_i;

endmodule

`default_nettype wire

//--- source/exec_top.sv
// Top level of the execution subsystem with a plain Wishbone slave port
// Connects host port, execution unit and register-file arbiter

`default_nettype none

module exec_top (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  logic               cyc_i,
  input  logic               stb_i,
  input  logic               we_i,
  input  exec_pkg::wb_addr_t adr_i,
  input  exec_pkg::data_t    dat_i,
  output exec_pkg::data_t    dat_o,
  output logic               ack_o
);

  // Issue handshake
  logic            instr_valid;
  logic            instr_ready;
  exec_pkg::data_t instr;

  // One access bundle per requester
  rf_req_if exec_rf ();
  rf_req_if host_rf ();

  wb_host_port i_wb_host_port (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cyc_i         (cyc_i),
    .stb_i         (stb_i),
    .we_i          (we_i),
    .adr_i         (adr_i),
    .dat_i         (dat_i),
    .dat_o         (dat_o),
    .ack_o         (ack_o),
    .instr_valid_o (instr_valid),
    .instr_o       (instr),
    .instr_ready_i (instr_ready),
    .rf            (host_rf.requester)
  );

  alu_exec i_alu_exec (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .instr_ready_o (instr_ready),
    .rf            (exec_rf.requester)
  );

  rf_arbiter i_rf_arbiter (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .exec_req (exec_rf.arbiter),
    .host_req (host_rf.arbiter)
  );

endmodule

`default_nettype wire

//--- sim/exec_tb.sv
// Testbench for the execution subsystem, drives Wishbone cycles from the pattern file
// Each pattern is a register write, an instruction issue or a read with expected data

`default_nettype none

module exec_tb;

  localparam int unsigned CLK_PERIOD    = 100;
  localparam int unsigned RESET_CYCLES  = 3;
  localparam int unsigned MAX_OPS       = 64;
  localparam int unsigned ACK_LIMIT     = 10;
  localparam int unsigned CYCLES_PER_OP = 20;

  // Pattern kinds, first column of the file
  localparam logic [31:0] KIND_WRITE = 32'd1;
  localparam logic [31:0] KIND_INSTR = 32'd2;
  localparam logic [31:0] KIND_READ  = 32'd3;

  logic               clk_i;
  logic               rst_ni;
  logic               cyc_i;
  logic               stb_i;
  logic               we_i;
  exec_pkg::wb_addr_t adr_i;
  exec_pkg::data_t    dat_i;
  exec_pkg::data_t    dat_o;
  logic               ack_o;

  // Three words per operation: kind, address, data or expected value
  exec_pkg::data_t pat_mem [0:3*MAX_OPS-1];
  int unsigned     num_ops;
  logic            loaded;

  int unsigned     err_data;
  int unsigned     err_ack;
  int unsigned     err_misc;
  integer          seed;

  exec_top i_exec_top (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .cyc_i  (cyc_i),
    .stb_i  (stb_i),
    .we_i   (we_i),
    .adr_i  (adr_i),
    .dat_i  (dat_i),
    .dat_o  (dat_o),
    .ack_o  (ack_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  // Zero-filled first, so the first kind of 0 marks the end
  task automatic load_patterns();
    for (int unsigned i = 0; i < 3*MAX_OPS; i++) begin
      pat_mem[i] = '0;
    end
    $readmemh("sim/exec_patterns.txt", pat_mem);
    num_ops = 0;
    while (num_ops < MAX_OPS && pat_mem[3*num_ops] != '0) begin
      num_ops++;
    end
    if (num_ops == 0) begin
      $display("No operations found in the pattern file");
      err_misc++;
    end
  endtask

  // One classic cycle, held until ack or until the limit runs out
  task automatic wb_access(input logic we, input exec_pkg::wb_addr_t adr,
                           input exec_pkg::data_t wdata,
                           output exec_pkg::data_t rdata, output logic acked);
    int unsigned waited;
    @(posedge clk_i);
    cyc_i <= 1'b1;
    stb_i <= 1'b1;
    we_i  <= we;
    adr_i <= adr;
    dat_i <= wdata;
    acked  = 1'b0;
    rdata  = '0;
    waited = 0;
    // Mid-cycle sampling, outputs settled
    while (!acked && waited < ACK_LIMIT) begin
      @(negedge clk_i);
      waited++;
      if (ack_o === 1'b1) begin
        acked = 1'b1;
        rdata = dat_o;
      end
    end
    @(posedge clk_i);
    cyc_i <= 1'b0;
    stb_i <= 1'b0;
    we_i  <= 1'b0;
  endtask

  task automatic check_data(input string name, input exec_pkg::data_t got,
                            input exec_pkg::data_t exp, input int unsigned idx,
                            input exec_pkg::wb_addr_t adr);
    if (got !== exp) begin
      $display("** Error: %s = 0x%08h, expected 0x%08h (op %0d, adr 0x%02h)",
               name, got, exp, idx, adr);
      err_data++;
    end
  endtask

  task automatic check_ack(input logic acked, input int unsigned idx,
                           input exec_pkg::wb_addr_t adr);
    if (!acked) begin
      $display("Operation %0d at address 0x%02h was not acknowledged within %0d cycles",
               idx, adr, ACK_LIMIT);
      err_ack++;
    end
  endtask

  task automatic run_op(input int unsigned idx);
    logic [31:0]        kind;
    exec_pkg::wb_addr_t adr;
    exec_pkg::data_t    word;
    exec_pkg::data_t    rdata;
    logic               acked;
    kind = pat_mem[3*idx];
    adr  = exec_pkg::wb_addr_t'(pat_mem[3*idx+1]);
    word = pat_mem[3*idx+2];
    case (kind)
      // Instruction issue is a write to the issue address
      KIND_WRITE, KIND_INSTR: begin
        wb_access(1'b1, adr, word, rdata, acked);
        check_ack(acked, idx, adr);
      end
      KIND_READ: begin
        wb_access(1'b0, adr, '0, rdata, acked);
        check_ack(acked, idx, adr);
        if (acked) begin
          check_data("dat_o", rdata, word, idx, adr);
        end
      end
      default: begin
        $display("Operation %0d has an unknown kind 0x%0h", idx, kind);
        err_misc++;
      end
    endcase
  endtask

  // Budget scales with the number of operations
  initial begin
    wait (loaded === 1'b1);
    #(CLK_PERIOD * (RESET_CYCLES + 10 + num_ops * CYCLES_PER_OP));
    $display("Watchdog expired before all operations finished");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    int unsigned gap;
    cyc_i    = 1'b0;
    stb_i    = 1'b0;
    we_i     = 1'b0;
    adr_i    = '0;
    dat_i    = '0;
    rst_ni   = 1'b0;
    loaded   = 1'b0;
    err_data = 0;
    err_ack  = 0;
    err_misc = 0;
    seed     = 32'h4baa;

    load_patterns();
    loaded = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int unsigned i = 0; i < num_ops; i++) begin
      // 0 to 3 idle cycles between operations
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(posedge clk_i);
      run_op(i);
    end

    repeat (2) @(posedge clk_i);
    $display("Done: %0d data errors, %0d ack errors, %0d other errors",
             err_data, err_ack, err_misc);
    if (err_data == 0 && err_ack == 0 && err_misc == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/exec_patterns.txt
// Columns: kind (1 write reg, 2 instruction, 3 read and compare), byte address, data
// Instruction word: op [18:16], rd [14:10], rs1 [9:5], rs2 [4:0]
3 04 00000000
3 7C 00000000
1 00 DEADBEEF
3 00 00000000
1 04 12345678
1 08 0F0F0F0F
1 0C FFFFFFF0
1 10 00000024
1 14 00000003
1 48 FFFFFFFF
3 04 12345678
3 0C FFFFFFF0
2 80 00002822
3 28 21436587
2 80 00012C22
3 2C 03254769
2 80 00023022
3 30 02040608
2 80 00033422
3 34 1F3F5F7F
2 80 00043822
3 38 1D3B5977
2 80 00053C24
3 3C 23456780
2 80 00064064
3 40 0FFFFFFF
2 80 00074465
3 44 00000001
2 80 000748A3
3 48 00000000
2 80 00004C02
3 4C 0F0F0F0F
2 80 00005020
3 50 12345678
2 80 00000022
3 00 00000000
1 90 CAFEF00D
3 90 00000000
3 C4 00000000
3 80 00000000

//--- compile.f
source/exec_pkg.sv
source/rf_req_if.sv
source/register_file.sv
source/rf_arbiter.sv
source/alu_exec.sv
source/wb_host_port.sv
source/exec_top.sv
sim/exec_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = exec_tb
FILELIST  = compile.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf obj_dir
